// ==== fetch_params.svh ====
// fetch front end constants
// reset pc, memory geometry, interrupt vector and the opcodes the injector uses
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// first pc after reset, also the base of instruction memory
`define FETCH_RESET_PC 32'h0600_2000

// instruction memory geometry in 32-bit words
`define IMEM_DEPTH 256
`define IMEM_AW 8

// interrupt handler entry
`define INT_VECTOR (`FETCH_RESET_PC + 32'h0000_0200)
// number of save words fed in before the handler
`define INT_SEQ_LEN 3

// opcodes, top 5 bits of the word
`define OP_SAVE 5'b10100
`define OP_RTI 5'b11010
`define OP_NOP 5'b01111

`endif

// ==== fetch_pkg.sv ====
// fetch front end types
// instruction word views, the packet to decode and the side-band structs
`default_nettype none
`include "fetch_params.svh"

package fetch_pkg;

	// field view of an instruction word
	typedef struct packed {
		logic [4:0]  opcode;
		logic [26:0] payload;
	} instr_fields_t;

	// fetch moves the raw word, the injector builds and matches fields
	typedef union packed {
		logic [31:0]   raw;
		instr_fields_t f;
	} instr_u;

	// packet handed to decode
	typedef struct packed {
		logic [31:0] pc;
		instr_u      instr;
		// word came from the injector, not from memory
		logic        injected;
	} fetch_pkt_t;

	// redirect pulse from execute
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
	} redirect_t;

	// injector to fetch
	typedef struct packed {
		logic        inject;
		instr_u      word;
		logic        jump;
		// jump target, or pc tagged on injected words
		logic [31:0] jump_pc;
	} inj_ctrl_t;

	// memory load port
	typedef struct packed {
		logic                en;
		logic [`IMEM_AW-1:0] addr;
		logic [31:0]         data;
	} imem_wr_t;

endpackage

`default_nettype wire

// ==== instr_mem.sv ====
// instruction memory
// word array with a synchronous load port and a registered read port,
// read data valid one cycle after rd_en and held while rd_en is low
`timescale 1ns/100ps
`default_nettype none
`include "fetch_params.svh"

module instr_mem (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire fetch_pkg::imem_wr_t wr,
	input  wire                      rd_en,
	input  wire [`IMEM_AW-1:0]       rd_addr,
	output logic [31:0]              rd_data
);

	// storage, contents come from the load port only
	logic [31:0] mem [`IMEM_DEPTH];

	// load port
	// written also while reset is held so the test can preload
	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// read port
	// one cycle latency
	// output holds when no read is issued, fetch relies on this under stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_data <= '0;
		end else if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

	// loads only happen while fetch is held or in reset,
	// so a read and a write to one word never meet
	// a collision here means the load was driven while fetch was running
	a_no_rd_wr_collide : assert property (
		@(posedge clk) disable iff (!rst_n)
		!(wr.en && rd_en && (wr.addr == rd_addr))
	);

endmodule

`default_nettype wire

// ==== fetch.sv ====
// fetch stage
// keeps the pc, reads instruction memory and registers a pc/word packet
// toward decode under a valid/ready handshake, with injected words muxed in
`timescale 1ns/100ps
`default_nettype none
`include "fetch_params.svh"

module fetch (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire fetch_pkg::redirect_t  redirect,
	input  wire fetch_pkg::inj_ctrl_t  inj,
	input  wire fetch_pkg::imem_wr_t   imem_wr,
	output fetch_pkg::fetch_pkt_t      out_pkt,
	output logic                       out_valid,
	input  wire                        out_ready,
	output logic [31:0]                resume_pc
);

	logic [31:0]         pc;
	// read in flight, issued last cycle
	logic [31:0]         rd_pc;
	logic                rd_valid;
	logic                rd_en;
	logic [31:0]         pc_off;
	logic [`IMEM_AW-1:0] rd_addr;
	logic [31:0]         rd_data;
	logic                stall;
	logic                flush;
	fetch_pkg::instr_u   nop_word;

	// decode holding the output packet
	assign stall = out_valid && !out_ready;
	// jump or redirect empties both stages
	assign flush = inj.jump || redirect.valid;

	// read only when the pipe moves and memory words are wanted
	assign rd_en = !flush && !stall && !inj.inject;

	// word index relative to the memory base, wraps at depth
	assign pc_off  = pc - `FETCH_RESET_PC;
	assign rd_addr = pc_off[`IMEM_AW+1:2];

	// flushed slot carries a nop
	always_comb begin
		nop_word          = '0;
		nop_word.f.opcode = `OP_NOP;
	end

	instr_mem imem0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (imem_wr),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// control: pc and stage valids
	// priority jump, redirect, hold, then inject or increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc        <= `FETCH_RESET_PC;
			rd_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else if (inj.jump) begin
			pc        <= inj.jump_pc;
			rd_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else if (redirect.valid) begin
			pc        <= redirect.pc;
			rd_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else if (!stall) begin
			if (inj.inject) begin
				// pending read dropped, refetched from the saved pc later
				rd_valid  <= 1'b0;
				out_valid <= 1'b1;
			end else begin
				pc        <= pc + 32'd4;
				rd_valid  <= 1'b1;
				out_valid <= rd_valid;
			end
		end
	end

	// payload: in-flight pc and output packet
	always_ff @(posedge clk) begin
		if (flush) begin
			out_pkt.instr    <= nop_word;
			out_pkt.injected <= 1'b0;
		end else if (!stall) begin
			if (inj.inject) begin
				out_pkt.pc       <= inj.jump_pc;
				out_pkt.instr    <= inj.word;
				out_pkt.injected <= 1'b1;
			end else begin
				rd_pc             <= pc;
				out_pkt.pc        <= rd_pc;
				out_pkt.instr.raw <= rd_data;
				out_pkt.injected  <= 1'b0;
			end
		end
	end

	// oldest pc not yet committed to decode
	// a stalled output packet is always delivered, so the next one counts
	// a redirect this cycle wins since everything older is dropped
	always_comb begin
		if (redirect.valid) begin
			resume_pc = redirect.pc;
		end else if (rd_valid) begin
			resume_pc = rd_pc;
		end else begin
			resume_pc = pc;
		end
	end

	// held packet stays put until decode takes it or a flush removes it
	a_stall_stable : assert property (
		@(posedge clk) disable iff (!rst_n)
		stall && !flush |=> out_valid && $stable(out_pkt)
	);

	// neither a jump nor a redirect is lost:
	// the stages empty and pc takes the winner's target
	a_flush_taken : assert property (
		@(posedge clk) disable iff (!rst_n)
		flush |=> !out_valid && (pc == $past(inj.jump ? inj.jump_pc : redirect.pc))
	);

endmodule

`default_nettype wire

// ==== int_inject.sv ====
// interrupt injector
// on a request saves the resume pc, feeds save words into fetch, jumps to
// the handler vector and jumps back to the saved pc on return-from-interrupt
`timescale 1ns/100ps
`default_nettype none
`include "fetch_params.svh"

module int_inject (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         irq,
	output logic                        irq_ack,
	input  wire [31:0]                  resume_pc,
	input  wire fetch_pkg::fetch_pkt_t  acc_pkt,
	input  wire                         acc,
	output fetch_pkg::inj_ctrl_t        ctrl
);

	// states
	localparam logic [1:0] S_IDLE    = 2'd0;
	localparam logic [1:0] S_INJECT  = 2'd1;
	localparam logic [1:0] S_HANDLER = 2'd2;
	localparam logic [1:0] S_RETURN  = 2'd3;

	// save word counter width
	localparam int CW = $clog2(`INT_SEQ_LEN + 1);

	logic [1:0]    state;
	logic [CW-1:0] cnt;
	logic [31:0]   saved_pc;
	logic          take;
	logic          save_acc;
	logic          last_save;
	logic          rti_acc;

	// request only taken when idle
	assign take = (state == S_IDLE) && irq;

	// decode of accepted packets at the fetch boundary
	// memory packets still draining do not count as save words
	assign save_acc  = acc && acc_pkt.injected;
	assign last_save = save_acc && (cnt == CW'(`INT_SEQ_LEN - 1));
	assign rti_acc   = acc && !acc_pkt.injected && (acc_pkt.instr.f.opcode == `OP_RTI);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			cnt     <= '0;
			irq_ack <= 1'b0;
		end else begin
			irq_ack <= take;
			case (state)
				S_IDLE: begin
					if (take) begin
						state <= S_INJECT;
					end
				end
				S_INJECT: begin
					// one step per transferred save word
					if (last_save) begin
						state <= S_HANDLER;
						cnt   <= '0;
					end else if (save_acc) begin
						cnt <= cnt + 1'b1;
					end
				end
				S_HANDLER: begin
					if (rti_acc) begin
						state <= S_RETURN;
					end
				end
				default: begin
					// pc reloads from saved_pc this cycle
					state <= S_IDLE;
				end
			endcase
		end
	end

	// resume point, sampled as the request is taken
	always_ff @(posedge clk) begin
		if (take) begin
			saved_pc <= resume_pc;
		end
	end

	// outputs to fetch
	// inject drops in the cycle the last save word leaves,
	// so fetch never loads a spare save word before the jump
	// a word loaded while a save word leaves is the one after it
	always_comb begin
		ctrl                = '0;
		ctrl.inject         = take || ((state == S_INJECT) && !last_save);
		ctrl.word.f.opcode  = `OP_SAVE;
		ctrl.word.f.payload = 27'(cnt) + 27'(save_acc);
		ctrl.jump           = ((state == S_INJECT) && last_save) ||
		                      ((state == S_HANDLER) && rti_acc);
		if ((state == S_INJECT) && last_save) begin
			ctrl.jump_pc = `INT_VECTOR;
		end else if (take) begin
			// saved_pc not loaded yet on the first save word
			ctrl.jump_pc = resume_pc;
		end else begin
			ctrl.jump_pc = saved_pc;
		end
	end

	// a jump never overlaps injection and is never followed by a save word
	a_jump_no_inject : assert property (
		@(posedge clk) disable iff (!rst_n)
		ctrl.jump |-> !ctrl.inject ##1 !ctrl.inject
	);

endmodule

`default_nettype wire

// ==== fetch_top.sv ====
// fetch front end top
// fetch stage with its instruction memory, and the interrupt injector
// watching the packets that decode accepts
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        irq,
	output logic                       irq_ack,
	input  wire fetch_pkg::redirect_t  redirect,
	input  wire fetch_pkg::imem_wr_t   imem_wr,
	output fetch_pkg::fetch_pkt_t      out_pkt,
	output logic                       out_valid,
	input  wire                        out_ready
);

	fetch_pkg::inj_ctrl_t inj_ctrl;
	logic [31:0]          resume_pc;
	// packet transfer to decode
	logic                 acc;

	assign acc = out_valid && out_ready;

	fetch fetch0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.redirect  (redirect),
		.inj       (inj_ctrl),
		.imem_wr   (imem_wr),
		.out_pkt   (out_pkt),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.resume_pc (resume_pc)
	);

	// sees the same boundary as decode
	int_inject inj0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.irq       (irq),
		.irq_ack   (irq_ack),
		.resume_pc (resume_pc),
		.acc_pkt   (out_pkt),
		.acc       (acc),
		.ctrl      (inj_ctrl)
	);

endmodule

`default_nettype wire

// ==== tb_fetch.sv ====
// fetch front end testbench
// directed tests for the memory stream, back-pressure, redirects and
// interrupt injection, checked against a reference model of the stream
`timescale 1ns/100ps
`default_nettype none
`include "fetch_params.svh"

module tb_fetch;

	// accepted packets per test, also sizes the watchdog
	localparam int N_T1 = 12;
	localparam int N_T2 = 40;
	localparam int N_T3 = 30;
	localparam int N_T4 = 16;
	localparam int N_T5 = 24;
	localparam int LIMIT_CYCLES = (N_T1 + N_T2 + N_T3 + N_T4 + N_T5) * 20;
	localparam int CYCLE_NS = 100;
	localparam int WAIT_LIMIT = 200;
	// model phases of an interrupt
	localparam int ST_RUN = 0;
	localparam int ST_SAVE = 1;
	localparam int ST_HANDLER = 2;

	logic                  clk;
	logic                  rst_n;
	logic                  irq;
	logic                  irq_ack;
	logic                  out_ready;
	logic                  out_valid;
	fetch_pkg::redirect_t  redirect;
	fetch_pkg::imem_wr_t   imem_wr;
	fetch_pkg::fetch_pkt_t out_pkt;

	// reference model
	logic [31:0]           ref_mem [`IMEM_DEPTH];
	logic [31:0]           exp_pc;
	logic [31:0]           saved_pc;
	int                    int_state;
	int                    save_k;
	// packet decode is holding, must not move
	logic                  held;
	fetch_pkg::fetch_pkt_t held_pkt;
	logic [31:0]           lcg_state;
	int                    acc_cnt;
	int                    errors;
	int                    checks;
	int                    tests_run;

	fetch_top dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.irq       (irq),
		.irq_ack   (irq_ack),
		.redirect  (redirect),
		.imem_wr   (imem_wr),
		.out_pkt   (out_pkt),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	always #(CYCLE_NS / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ready about three cycles out of four
	function automatic logic random_ready();
		logic [31:0] r;
		r = lcg_next();
		return r[16] | r[9];
	endfunction

	// word index of a pc, wraps at memory depth
	function automatic logic [`IMEM_AW-1:0] mem_index(input logic [31:0] pc);
		logic [31:0] off;
		off = (pc - `FETCH_RESET_PC) >> 2;
		return `IMEM_AW'(off % `IMEM_DEPTH);
	endfunction

	task automatic model_reset();
		exp_pc = `FETCH_RESET_PC;
		int_state = ST_RUN;
		save_k = 0;
		held = 1'b0;
	endtask

	task automatic reset_dut();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		model_reset();
	endtask

	// compare one accepted packet with the expected stream
	task automatic check_packet(input fetch_pkg::fetch_pkt_t p);
		acc_cnt++;
		checks++;
		if (p.injected) begin
			assert (int_state == ST_SAVE && p.instr.f.opcode == `OP_SAVE &&
				p.instr.f.payload == 27'(save_k) && p.pc == exp_pc) else begin
				$display("error %0t: save word %0d pc %h word %h, expected pc %h",
					$time, save_k, p.pc, p.instr.raw, exp_pc);
				errors++;
			end
			save_k++;
			// last save word, handler follows
			if (save_k == `INT_SEQ_LEN) begin
				saved_pc = exp_pc;
				exp_pc = `INT_VECTOR;
				int_state = ST_HANDLER;
			end
		end else begin
			assert (p.pc == exp_pc && p.instr.raw == ref_mem[mem_index(exp_pc)]) else begin
				$display("error %0t: pc %h word %h, expected pc %h word %h",
					$time, p.pc, p.instr.raw, exp_pc, ref_mem[mem_index(exp_pc)]);
				errors++;
			end
			if (int_state == ST_HANDLER && p.instr.f.opcode == `OP_RTI) begin
				exp_pc = saved_pc;
				int_state = ST_RUN;
			end else begin
				exp_pc = exp_pc + 32'd4;
			end
		end
	endtask

	// one clock: drive on the falling edge, then check what transfers next
	task automatic step(input logic ready, input logic redir, input logic [31:0] target);
		@(negedge clk);
		if (held) begin
			checks++;
			assert (out_valid && out_pkt == held_pkt) else begin
				$display("error %0t: packet changed while stalled, pc %h", $time, out_pkt.pc);
				errors++;
			end
		end
		out_ready = ready;
		redirect.valid = redir;
		redirect.pc = target;
		if (irq_ack) begin
			checks++;
			assert (int_state == ST_RUN) else begin
				$display("error %0t: irq_ack pulsed during an interrupt", $time);
				errors++;
			end
			int_state = ST_SAVE;
			save_k = 0;
		end
		if (out_valid && ready) begin
			check_packet(out_pkt);
		end
		held = out_valid && !ready && !redir;
		held_pkt = out_pkt;
		if (redir) begin
			exp_pc = target;
		end
	endtask

	// step until n more packets transfer
	task automatic run_packets(input int n, input logic random);
		int target;
		int cycles;
		target = acc_cnt + n;
		cycles = 0;
		while (acc_cnt < target && cycles < n * 20) begin
			step(random ? random_ready() : 1'b1, 1'b0, 32'd0);
			cycles++;
		end
		if (acc_cnt < target) begin
			$display("no progress: %0d of %0d packets accepted", n - (target - acc_cnt), n);
			errors++;
		end
	endtask

	task automatic wait_state(input int want);
		int cycles;
		cycles = 0;
		while (int_state != want && cycles < WAIT_LIMIT) begin
			step(random_ready(), 1'b0, 32'd0);
			cycles++;
		end
		if (int_state != want) begin
			$display("interrupt sequence stuck before phase %0d", want);
			errors++;
		end
	endtask

	task automatic take_irq();
		irq = 1'b1;
		wait_state(ST_SAVE);
		irq = 1'b0;
	endtask

	task automatic load_memory();
		logic [31:0]         word;
		logic [`IMEM_AW-1:0] idx;
		logic [`IMEM_AW-1:0] rti_idx;
		int                  i;
		int                  cycles;
		rti_idx = mem_index(`INT_VECTOR + 32'd8);
		out_ready = 1'b0;
		cycles = 0;
		// fetch fills and stalls, so no reads meet the loads
		while (!out_valid && cycles < 10) begin
			@(negedge clk);
			cycles++;
		end
		if (!out_valid) begin
			$display("fetch did not stall before the memory load");
			errors++;
		end
		for (i = 0; i < `IMEM_DEPTH; i++) begin
			idx = `IMEM_AW'(i);
			word = lcg_next();
			// only the handler holds a return-from-interrupt
			if (word[31:27] == `OP_RTI) begin
				word[31] = ~word[31];
			end
			if (idx == rti_idx) begin
				word = {`OP_RTI, 27'(i)};
			end
			@(negedge clk);
			imem_wr.en = 1'b1;
			imem_wr.addr = idx;
			imem_wr.data = word;
			ref_mem[idx] = word;
		end
		@(negedge clk);
		imem_wr = '0;
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %s done, no errors", name);
		end else begin
			$display("test %s done, %0d errors", name, errors - err_start);
		end
	endtask

	task automatic test_reset_stream();
		int e;
		e = errors;
		out_ready = 1'b1;
		reset_dut();
		step(1'b1, 1'b0, 32'd0);
		checks++;
		assert (!out_valid) else begin
			$display("error %0t: out_valid high one cycle after reset", $time);
			errors++;
		end
		step(1'b1, 1'b0, 32'd0);
		checks++;
		assert (out_valid) else begin
			$display("error %0t: no packet two cycles after reset", $time);
			errors++;
		end
		run_packets(N_T1 - 1, 1'b0);
		end_test("reset_stream", e);
	endtask

	task automatic test_backpressure();
		int e;
		e = errors;
		run_packets(N_T2, 1'b1);
		end_test("backpressure", e);
	endtask

	task automatic test_redirect();
		int e;
		int i;
		e = errors;
		run_packets(10, 1'b1);
		// near the top of memory, the stream wraps to index 0
		step(1'b1, 1'b1, `FETCH_RESET_PC + 32'd1000);
		run_packets(10, 1'b1);
		i = 0;
		while (!out_valid && i < 4) begin
			step(1'b0, 1'b0, 32'd0);
			i++;
		end
		// redirect while decode holds a packet
		step(1'b0, 1'b1, `FETCH_RESET_PC + 32'd240);
		run_packets(10, 1'b1);
		end_test("redirect", e);
	endtask

	task automatic test_irq_entry();
		int e;
		e = errors;
		run_packets(4, 1'b1);
		take_irq();
		wait_state(ST_HANDLER);
		run_packets(2, 1'b1);
		end_test("irq_entry", e);
	endtask

	task automatic test_irq_return();
		int e;
		e = errors;
		wait_state(ST_RUN);
		run_packets(8, 1'b1);
		take_irq();
		wait_state(ST_HANDLER);
		wait_state(ST_RUN);
		run_packets(8, 1'b1);
		end_test("irq_return", e);
	endtask

	// watchdog
	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, run stopped", LIMIT_CYCLES);
		$display("sim failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		irq = 1'b0;
		out_ready = 1'b0;
		redirect = '0;
		imem_wr = '0;
		lcg_state = 32'd78447;
		acc_cnt = 0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		saved_pc = '0;
		model_reset();
		reset_dut();
		load_memory();
		test_reset_stream();
		test_backpressure();
		test_redirect();
		test_irq_entry();
		test_irq_return();
		$display("tests %0d, packets %0d, checks %0d, errors %0d",
			tests_run, acc_cnt, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
fetch_pkg.sv
instr_mem.sv
fetch.sv
int_inject.sv
fetch_top.sv
tb_fetch.sv

// ==== Makefile ====
# Verilator build and run of the fetch front end testbench
TOP = tb_fetch

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || echo "sim failed" >> sim.log
	@cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: help test clean
